// ==== cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Datapath and instruction word width
`define CPU_DBITS           32
`define CPU_REGNO_BITS      4

// Word-address bits of each memory
`define CPU_IMEM_ADDR_BITS  10
`define CPU_DMEM_ADDR_BITS  10

// Bytes per instruction, PC steps by this
`define CPU_INST_SIZE       32'd4
`define CPU_START_PC        32'h100

// Memory-mapped display
`define CPU_ADDR_HEX        32'hFFFFF000
`define CPU_HEX_BITS        24
`define CPU_HEX_RESET       24'hFEDEAD

`endif

// ==== cpu_pkg.sv ====
`include "cpu_cfg.svh"

package cpu_pkg;

  // Primary opcode, bits 31:26
  typedef enum logic [5:0] {
    OP1_ALUR = 6'b000000,
    OP1_BEQ  = 6'b001000,
    OP1_BLT  = 6'b001001,
    OP1_BLE  = 6'b001010,
    OP1_BNE  = 6'b001011,
    OP1_JAL  = 6'b001100,
    OP1_LW   = 6'b010010,
    OP1_SW   = 6'b011010,
    OP1_ADDI = 6'b100000,
    OP1_ANDI = 6'b100100,
    OP1_ORI  = 6'b100101,
    OP1_XORI = 6'b100110
  } op1_e;

  // ALU function for register-form instructions
  typedef enum logic [7:0] {
    OP2_EQ   = 8'b00001000,
    OP2_LT   = 8'b00001001,
    OP2_LE   = 8'b00001010,
    OP2_NE   = 8'b00001011,
    OP2_ADD  = 8'b00100000,
    OP2_AND  = 8'b00100100,
    OP2_OR   = 8'b00100101,
    OP2_XOR  = 8'b00100110,
    OP2_SUB  = 8'b00101000,
    OP2_NAND = 8'b00101100,
    OP2_NOR  = 8'b00101101,
    OP2_NXOR = 8'b00101110,
    OP2_RSHF = 8'b00110000,
    OP2_LSHF = 8'b00110001
  } op2_e;

  typedef struct packed {
    op1_e                       op1;
    op2_e                       op2;
    logic [5:0]                 pad;
    logic [`CPU_REGNO_BITS-1:0] rd;
    logic [`CPU_REGNO_BITS-1:0] rs;
    logic [`CPU_REGNO_BITS-1:0] rt;
  } inst_r_t;

  typedef struct packed {
    op1_e                       op1;
    logic [1:0]                 pad;
    logic [15:0]                imm;
    logic [`CPU_REGNO_BITS-1:0] rs;
    logic [`CPU_REGNO_BITS-1:0] rt;
  } inst_i_t;

  // Bits 25:8 hold either op2/rd or imm16
  typedef union packed {
    inst_r_t r;
    inst_i_t i;
  } inst_u;

  typedef enum logic [1:0] {
    ALU_RT   = 2'b00,
    ALU_IMM  = 2'b01,
    ALU_IMM4 = 2'b10  // Word offset for JAL
  } alu_src_e;

  typedef enum logic [1:0] {
    WB_PC  = 2'b00,
    WB_MEM = 2'b01,
    WB_ALU = 2'b10
  } wb_src_e;

  typedef struct packed {
    alu_src_e alu_src;
    logic     mem_we;
    logic     reg_we;
    wb_src_e  wb_src;
    logic     dst_is_rd;
    logic     is_branch;
    logic     is_jal;
  } ctrl_t;

  typedef struct packed {
    logic                 valid;
    logic [`CPU_DBITS-1:0] pc;
    inst_u                inst;
  } fe_latch_t;

  typedef struct packed {
    logic                       valid;
    logic [`CPU_DBITS-1:0]      pc;
    op1_e                       op1;
    op2_e                       op2;
    ctrl_t                      ctrl;
    logic [`CPU_DBITS-1:0]      rs_val;
    logic [`CPU_DBITS-1:0]      rt_val;
    logic [`CPU_DBITS-1:0]      imm;
    logic [`CPU_REGNO_BITS-1:0] dst;
  } id_latch_t;

  typedef struct packed {
    logic                       valid;
    logic [`CPU_DBITS-1:0]      pc_next;  // Link value
    logic [`CPU_DBITS-1:0]      alu_out;
    logic [`CPU_DBITS-1:0]      store_val;
    logic [`CPU_REGNO_BITS-1:0] dst;
    logic                       mem_we;
    logic                       reg_we;
    wb_src_e                    wb_src;
  } ex_latch_t;

  typedef struct packed {
    logic                       valid;
    logic                       reg_we;
    logic [`CPU_REGNO_BITS-1:0] dst;
    logic [`CPU_DBITS-1:0]      data;
  } wb_t;

endpackage

// ==== cpu_top.f ====
+incdir+.
cpu_pkg.sv
fetch_unit.sv
decode_unit.sv
reg_file.sv
exec_unit.sv
mem_unit.sv
cpu_top.sv
tb_cpu.sv

// ==== cpu_top.sv ====
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module cpu_top (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           run,
  input  logic                           imem_wr,
  input  logic [`CPU_IMEM_ADDR_BITS-1:0] imem_addr,
  input  logic [`CPU_DBITS-1:0]          imem_data,
  output logic [`CPU_HEX_BITS-1:0]       hex_value,
  output logic                           hex_wr
);
  import cpu_pkg::*;

  fe_latch_t                  fe;
  id_latch_t                  id;
  ex_latch_t                  ex;
  wb_t                        wb;
  logic                       stall;
  logic                       redirect;
  logic [`CPU_DBITS-1:0]      redirect_pc;
  logic [`CPU_REGNO_BITS-1:0] rs_addr;
  logic [`CPU_REGNO_BITS-1:0] rt_addr;
  logic [`CPU_DBITS-1:0]      rs_val;
  logic [`CPU_DBITS-1:0]      rt_val;

  // Input side
  fetch_unit u_fetch (.clk, .reset, .run, .imem_wr, .imem_addr, .imem_data,
                      .stall, .redirect, .redirect_pc, .fe);

  // Processing
  decode_unit u_decode (.clk, .reset, .fe, .rs_addr, .rt_addr, .rs_val, .rt_val,
                        .ex_q(ex), .wb, .stall, .id);

  reg_file u_regs (.clk, .reset, .rs_addr, .rt_addr, .rs_val, .rt_val, .wb);

  exec_unit u_exec (.clk, .reset, .id, .redirect, .redirect_pc, .ex);

  // Output side
  mem_unit u_mem (.clk, .reset, .ex, .hex_value, .hex_wr, .wb);

endmodule

// ==== decode_unit.sv ====
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module decode_unit (
  input  logic                        clk,
  input  logic                        reset,
  input  cpu_pkg::fe_latch_t          fe,
  output logic [`CPU_REGNO_BITS-1:0]  rs_addr,
  output logic [`CPU_REGNO_BITS-1:0]  rt_addr,
  input  logic [`CPU_DBITS-1:0]       rs_val,
  input  logic [`CPU_DBITS-1:0]       rt_val,
  input  cpu_pkg::ex_latch_t          ex_q,
  input  cpu_pkg::wb_t                wb,
  output logic                        stall,
  output cpu_pkg::id_latch_t          id
);
  import cpu_pkg::*;

  op1_e                       op1;
  ctrl_t                      ctrl;
  logic [`CPU_DBITS-1:0]      imm_sxt;
  logic [`CPU_REGNO_BITS-1:0] dst;
  logic                       reads_rt;
  logic                       rs_busy;
  logic                       rt_busy;
  logic                       data_haz;
  logic                       br_in_id;
  logic                       br_in_ex;
  logic                       bubble;

  // Register r is the pending destination of one in-flight instruction
  function automatic logic pending(input logic v, input logic we,
                                   input logic [`CPU_REGNO_BITS-1:0] d,
                                   input logic [`CPU_REGNO_BITS-1:0] r);
    return v & we & (d == r);
  endfunction

  assign op1     = fe.inst.r.op1;
  assign rs_addr = fe.inst.r.rs;
  assign rt_addr = fe.inst.r.rt;
  assign imm_sxt = {{(`CPU_DBITS-16){fe.inst.i.imm[15]}}, fe.inst.i.imm};
  assign dst     = ctrl.dst_is_rd ? fe.inst.r.rd : fe.inst.r.rt;

  always_comb begin
    ctrl = '0;  // Unknown opcodes act as a no-op
    case (op1)
      OP1_ALUR: begin
        ctrl.reg_we    = 1'b1;
        ctrl.wb_src    = WB_ALU;
        ctrl.dst_is_rd = 1'b1;
      end
      OP1_BEQ, OP1_BLT, OP1_BLE, OP1_BNE: begin
        ctrl.is_branch = 1'b1;
      end
      OP1_JAL: begin
        ctrl.alu_src = ALU_IMM4;
        ctrl.reg_we  = 1'b1;
        ctrl.wb_src  = WB_PC;   // Link
        ctrl.is_jal  = 1'b1;
      end
      OP1_LW: begin
        ctrl.alu_src = ALU_IMM;
        ctrl.reg_we  = 1'b1;
        ctrl.wb_src  = WB_MEM;
      end
      OP1_SW: begin
        ctrl.alu_src = ALU_IMM;
        ctrl.mem_we  = 1'b1;
      end
      OP1_ADDI, OP1_ANDI, OP1_ORI, OP1_XORI: begin
        ctrl.alu_src = ALU_IMM;
        ctrl.reg_we  = 1'b1;
        ctrl.wb_src  = WB_ALU;
      end
      default: ;
    endcase
  end

  // rt is a source only for these formats
  assign reads_rt = op1 inside {OP1_ALUR, OP1_BEQ, OP1_BLT, OP1_BLE, OP1_BNE, OP1_SW};

  assign rs_busy = pending(id.valid, id.ctrl.reg_we, id.dst, rs_addr) |
                   pending(ex_q.valid, ex_q.reg_we, ex_q.dst, rs_addr) |
                   pending(wb.valid, wb.reg_we, wb.dst, rs_addr);
  assign rt_busy = pending(id.valid, id.ctrl.reg_we, id.dst, rt_addr) |
                   pending(ex_q.valid, ex_q.reg_we, ex_q.dst, rt_addr) |
                   pending(wb.valid, wb.reg_we, wb.dst, rt_addr);

  assign data_haz = fe.valid & (rs_busy | (reads_rt & rt_busy));
  assign br_in_id = fe.valid & (ctrl.is_branch | ctrl.is_jal);
  assign br_in_ex = id.valid & (id.ctrl.is_branch | id.ctrl.is_jal);

  // A branch in decode still issues; only fetch holds behind it
  assign bubble = data_haz | br_in_ex;
  assign stall  = bubble | br_in_id;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      id <= '0;
    end else begin
      id.valid  <= fe.valid & ~bubble;
      id.pc     <= fe.pc;
      id.op1    <= op1;
      id.op2    <= fe.inst.r.op2;
      id.ctrl   <= ctrl;
      id.rs_val <= rs_val;
      id.rt_val <= rt_val;
      id.imm    <= imm_sxt;
      id.dst    <= dst;
    end
  end

endmodule

// ==== exec_unit.sv ====
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module exec_unit (
  input  logic                  clk,
  input  logic                  reset,
  input  cpu_pkg::id_latch_t    id,
  output logic                  redirect,
  output logic [`CPU_DBITS-1:0] redirect_pc,
  output cpu_pkg::ex_latch_t    ex
);
  import cpu_pkg::*;

  localparam int SH_BITS = $clog2(`CPU_DBITS);

  logic signed [`CPU_DBITS-1:0] a;
  logic signed [`CPU_DBITS-1:0] b;
  logic [`CPU_DBITS-1:0]        imm4;
  logic [`CPU_DBITS-1:0]        pc_plus;
  logic [`CPU_DBITS-1:0]        alu_out;
  logic                         taken;

  assign a       = id.rs_val;
  assign imm4    = id.imm << 2;
  assign pc_plus = id.pc + `CPU_INST_SIZE;

  always_comb begin
    case (id.ctrl.alu_src)
      ALU_IMM:  b = id.imm;
      ALU_IMM4: b = imm4;
      default:  b = id.rt_val;
    endcase
  end

  // Signed ALU, compare ops return 0 or 1
  always_comb begin
    alu_out = '0;
    case (id.op1)
      OP1_ALUR: begin
        case (id.op2)
          OP2_EQ:   alu_out = {{(`CPU_DBITS-1){1'b0}}, a == b};
          OP2_LT:   alu_out = {{(`CPU_DBITS-1){1'b0}}, a < b};
          OP2_LE:   alu_out = {{(`CPU_DBITS-1){1'b0}}, a <= b};
          OP2_NE:   alu_out = {{(`CPU_DBITS-1){1'b0}}, a != b};
          OP2_ADD:  alu_out = a + b;
          OP2_AND:  alu_out = a & b;
          OP2_OR:   alu_out = a | b;
          OP2_XOR:  alu_out = a ^ b;
          OP2_SUB:  alu_out = a - b;
          OP2_NAND: alu_out = ~(a & b);
          OP2_NOR:  alu_out = ~(a | b);
          OP2_NXOR: alu_out = ~(a ^ b);
          OP2_RSHF: alu_out = a >>> b[SH_BITS-1:0];  // Arithmetic
          OP2_LSHF: alu_out = a << b[SH_BITS-1:0];
          default:  alu_out = '0;
        endcase
      end
      OP1_LW, OP1_SW, OP1_ADDI: alu_out = a + b;  // Address or sum
      OP1_ANDI:                 alu_out = a & b;
      OP1_ORI:                  alu_out = a | b;
      OP1_XORI:                 alu_out = a ^ b;
      default:                  alu_out = '0;
    endcase
  end

  always_comb begin
    case (id.op1)
      OP1_BEQ: taken = (a == b);
      OP1_BLT: taken = (a < b);
      OP1_BLE: taken = (a <= b);
      OP1_BNE: taken = (a != b);
      default: taken = 1'b0;
    endcase
  end

  // Every branch redirects, not-taken ones to the fall-through PC
  assign redirect    = id.valid & (id.ctrl.is_branch | id.ctrl.is_jal);
  assign redirect_pc = id.ctrl.is_jal ? a + imm4 :
                       taken          ? pc_plus + imm4 :
                                        pc_plus;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ex <= '0;
    end else begin
      ex.valid     <= id.valid;
      ex.pc_next   <= pc_plus;
      ex.alu_out   <= alu_out;
      ex.store_val <= id.rt_val;
      ex.dst       <= id.dst;
      ex.mem_we    <= id.ctrl.mem_we;
      ex.reg_we    <= id.ctrl.reg_we;
      ex.wb_src    <= id.ctrl.wb_src;
    end
  end

endmodule

// ==== fetch_unit.sv ====
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module fetch_unit (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           run,
  input  logic                           imem_wr,
  input  logic [`CPU_IMEM_ADDR_BITS-1:0] imem_addr,
  input  logic [`CPU_DBITS-1:0]          imem_data,
  input  logic                           stall,
  input  logic                           redirect,
  input  logic [`CPU_DBITS-1:0]          redirect_pc,
  output cpu_pkg::fe_latch_t             fe
);
  import cpu_pkg::*;

  localparam int WORD_LSB = $clog2(`CPU_INST_SIZE);

  logic [`CPU_DBITS-1:0] imem [0:(1 << `CPU_IMEM_ADDR_BITS)-1];
  logic [`CPU_DBITS-1:0] pc;
  inst_u                 fetch_word;

  assign fetch_word = imem[pc[`CPU_IMEM_ADDR_BITS+WORD_LSB-1:WORD_LSB]];

  // Load port, only while the core is halted
  always_ff @(posedge clk) begin
    if (imem_wr && !run) begin
      imem[imem_addr] <= imem_data;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc <= `CPU_START_PC;
      fe <= '0;
    end else if (!run) begin
      pc       <= `CPU_START_PC;
      fe.valid <= 1'b0;
    end else if (redirect) begin
      // Branch resolved in execute wins over a stall
      pc       <= redirect_pc;
      fe.valid <= 1'b0;
    end else if (!stall) begin
      pc       <= pc + `CPU_INST_SIZE;
      fe.valid <= 1'b1;
      fe.pc    <= pc;
      fe.inst  <= fetch_word;
    end
  end

endmodule

// ==== mem_unit.sv ====
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module mem_unit (
  input  logic                     clk,
  input  logic                     reset,
  input  cpu_pkg::ex_latch_t       ex,
  output logic [`CPU_HEX_BITS-1:0] hex_value,
  output logic                     hex_wr,
  output cpu_pkg::wb_t             wb
);
  import cpu_pkg::*;

  localparam int WORD_LSB = $clog2(`CPU_INST_SIZE);

  logic [`CPU_DBITS-1:0]          dmem [0:(1 << `CPU_DMEM_ADDR_BITS)-1];
  logic [`CPU_DMEM_ADDR_BITS-1:0] word_addr;
  logic [`CPU_DBITS-1:0]          load_val;
  logic [`CPU_DBITS-1:0]          wb_data;
  logic                           store;
  logic                           to_hex;

  assign word_addr = ex.alu_out[`CPU_DMEM_ADDR_BITS+WORD_LSB-1:WORD_LSB];
  assign load_val  = dmem[word_addr];
  assign store     = ex.valid & ex.mem_we;
  assign to_hex    = (ex.alu_out == `CPU_ADDR_HEX);

  // Display stores never reach data memory
  always_ff @(posedge clk) begin
    if (store && !to_hex) begin
      dmem[word_addr] <= ex.store_val;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hex_value <= `CPU_HEX_RESET;
      hex_wr    <= 1'b0;
    end else begin
      hex_wr <= store & to_hex;  // One-cycle strobe
      if (store && to_hex) begin
        hex_value <= ex.store_val[`CPU_HEX_BITS-1:0];
      end
    end
  end

  always_comb begin
    case (ex.wb_src)
      WB_PC:   wb_data = ex.pc_next;
      WB_MEM:  wb_data = load_val;
      default: wb_data = ex.alu_out;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wb <= '0;
    end else begin
      wb.valid  <= ex.valid;
      wb.reg_we <= ex.reg_we;
      wb.dst    <= ex.dst;
      wb.data   <= wb_data;
    end
  end

endmodule

// ==== reg_file.sv ====
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module reg_file (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [`CPU_REGNO_BITS-1:0] rs_addr,
  input  logic [`CPU_REGNO_BITS-1:0] rt_addr,
  output logic [`CPU_DBITS-1:0]      rs_val,
  output logic [`CPU_DBITS-1:0]      rt_val,
  input  cpu_pkg::wb_t               wb
);

  logic [`CPU_DBITS-1:0] regs [0:(1 << `CPU_REGNO_BITS)-1];

  assign rs_val = regs[rs_addr];
  assign rt_val = regs[rt_addr];

  // Write in mid-cycle so decode sees the value before the next rising edge
  always_ff @(negedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < (1 << `CPU_REGNO_BITS); i++) begin
        regs[i] <= '0;
      end
    end else if (wb.valid && wb.reg_we) begin
      regs[wb.dst] <= wb.data;
    end
  end

endmodule

// ==== tb_programs.svh ====
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// Register form fields op1, op2, pad, rd, rs, rt
function automatic logic [31:0] encode_reg(op2_e f, logic [3:0] rd, logic [3:0] rs,
                                           logic [3:0] rt);
  return {OP1_ALUR, f, 6'b000000, rd, rs, rt};
endfunction

// Immediate form writes rt from rs and imm16
function automatic logic [31:0] encode_imm(op1_e op, logic [3:0] rt, logic [3:0] rs,
                                           logic [15:0] imm);
  return {op, 2'b00, imm, rs, rt};
endfunction

// Branch compares rs against rt with a word offset
function automatic logic [31:0] branch_word(op1_e op, logic [3:0] rs, logic [3:0] rt,
                                            logic [15:0] off);
  return encode_imm(op, rt, rs, off);
endfunction

// r0 stays zero, so imm16 sign-extends to the display address
function automatic logic [31:0] display_store(logic [3:0] r);
  return encode_imm(OP1_SW, r, 4'd0, 16'(`CPU_ADDR_HEX));
endfunction

function automatic logic [31:0] halt_word();
  return branch_word(OP1_BEQ, 4'd0, 4'd0, 16'hFFFF);  // Branch to itself
endfunction

task automatic start_program();
  prog.delete();
  expected.delete();
endtask

task automatic expect_hex(logic [31:0] v);
  expected.push_back(v[`CPU_HEX_BITS-1:0]);
endtask

// Three instructions build any 32-bit value when r15 holds 16
task automatic load_word(logic [3:0] rd, logic [31:0] value);
  logic [15:0] hi;
  hi = value[31:16] ^ {16{value[15]}};  // Undo the sign extension of XORI
  prog.push_back(encode_imm(OP1_ADDI, rd, 4'd0, hi));
  prog.push_back(encode_reg(OP2_LSHF, rd, rd, 4'd15));
  prog.push_back(encode_imm(OP1_XORI, rd, rd, value[15:0]));
endtask

`endif

// ==== tb_cpu.sv ====
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module tb_cpu;
  import cpu_pkg::*;

  localparam int WATCHDOG_CYCLES = 2000;
  localparam int DRAIN_CYCLES    = 20;   // Quiet window after the last strobe
  localparam int START_WORD      = `CPU_START_PC / `CPU_INST_SIZE;

  logic                           clk;
  logic                           reset;
  logic                           run;
  logic                           imem_wr;
  logic [`CPU_IMEM_ADDR_BITS-1:0] imem_addr;
  logic [`CPU_DBITS-1:0]          imem_data;
  logic [`CPU_HEX_BITS-1:0]       hex_value;
  logic                           hex_wr;

  logic [31:0]              prog [$];
  logic [`CPU_HEX_BITS-1:0] expected [$];
  logic [`CPU_HEX_BITS-1:0] seen [$];
  logic [31:0]              lfsr_state = 32'h321e34dc;
  int                       cycle_cnt = 0;

  op2_e alu_ops [14] = '{OP2_EQ, OP2_LT, OP2_LE, OP2_NE, OP2_ADD, OP2_AND, OP2_OR,
                         OP2_XOR, OP2_SUB, OP2_NAND, OP2_NOR, OP2_NXOR, OP2_RSHF, OP2_LSHF};
  op1_e imm_ops [4]  = '{OP1_ADDI, OP1_ANDI, OP1_ORI, OP1_XORI};

  `include "tb_programs.svh"

  cpu_top u_dut (.clk, .reset, .run, .imem_wr, .imem_addr, .imem_data, .hex_value, .hex_wr);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(negedge clk) begin
    if (hex_wr) seen.push_back(hex_value);  // Both settled since the rising edge
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > WATCHDOG_CYCLES) begin
      $display("Timeout, the program did not produce its display writes in %0d cycles",
               WATCHDOG_CYCLES);
      stop_failed();
    end
  end

  task automatic stop_failed();
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_word(string name, logic [`CPU_HEX_BITS-1:0] exp,
                            logic [`CPU_HEX_BITS-1:0] act);
    if (act !== exp) begin
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
      stop_failed();
    end
  endtask

  task automatic check_count(string name, int exp, int act);
    if (act != exp) begin
      $display("ERROR %s: expected %0d display writes, actual %0d", name, exp, act);
      stop_failed();
    end
  endtask

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] pc_of(int idx);
    return `CPU_START_PC + idx * `CPU_INST_SIZE;
  endfunction

  // Signed compares give 0 or 1 and shifts use the low five bits of b
  function automatic logic [31:0] alu_expect(op2_e f, logic [31:0] a, logic [31:0] b);
    logic [31:0] r;
    case (f)
      OP2_EQ:   r = (a == b) ? 32'd1 : 32'd0;
      OP2_LT:   r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      OP2_LE:   r = ($signed(a) <= $signed(b)) ? 32'd1 : 32'd0;
      OP2_NE:   r = (a != b) ? 32'd1 : 32'd0;
      OP2_ADD:  r = a + b;
      OP2_AND:  r = a & b;
      OP2_OR:   r = a | b;
      OP2_XOR:  r = a ^ b;
      OP2_SUB:  r = a - b;
      OP2_NAND: r = ~(a & b);
      OP2_NOR:  r = ~(a | b);
      OP2_NXOR: r = ~(a ^ b);
      OP2_RSHF: r = $signed(a) >>> b[4:0];
      OP2_LSHF: r = a << b[4:0];
      default:  r = 'x;
    endcase
    return r;
  endfunction

  function automatic logic [31:0] imm_expect(op1_e op, logic [31:0] a, logic [15:0] imm);
    logic [31:0] s;
    s = {{16{imm[15]}}, imm};
    case (op)
      OP1_ADDI: return a + s;
      OP1_ANDI: return a & s;
      OP1_ORI:  return a | s;
      default:  return a ^ s;
    endcase
  endfunction

  function automatic bit branch_expect(op1_e op, logic [31:0] a, logic [31:0] b);
    case (op)
      OP1_BEQ: return a == b;
      OP1_BLT: return $signed(a) < $signed(b);
      OP1_BLE: return $signed(a) <= $signed(b);
      default: return a != b;
    endcase
  endfunction

  task automatic step_clock();
    @(posedge clk);
    #2;
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    repeat (16) step_clock();
    reset = 1'b0;
  endtask

  // Writes the program word by word through the load port
  task automatic load_program();
    for (int i = 0; i < prog.size(); i++) begin
      imem_wr   = 1'b1;
      imem_addr = START_WORD[`CPU_IMEM_ADDR_BITS-1:0] + i[`CPU_IMEM_ADDR_BITS-1:0];
      imem_data = prog[i];
      step_clock();
    end
    imem_wr = 1'b0;
  endtask

  // Load while halted, then reset and run until every expected write shows up
  task automatic run_program(string name);
    cycle_cnt = 0;
    load_program();
    apply_reset();
    check_word({name, " reset"}, `CPU_HEX_RESET, hex_value);
    seen.delete();
    run = 1'b1;
    while (seen.size() < expected.size()) step_clock();
    repeat (DRAIN_CYCLES) step_clock();
    run = 1'b0;
    for (int i = 0; i < expected.size(); i++) begin
      check_word($sformatf("%s[%0d]", name, i), expected[i], seen[i]);
    end
    check_count(name, expected.size(), seen.size());
  endtask

  // A display store waits at the start PC while run stays low
  task automatic idle_after_reset(string name);
    int strobes;
    strobes = 0;
    start_program();
    prog.push_back(display_store(4'd0));
    prog.push_back(halt_word());
    load_program();
    repeat (20) begin
      @(negedge clk);
      if (hex_wr !== 1'b0) strobes++;
    end
    step_clock();
    check_word(name, `CPU_HEX_RESET, hex_value);
    check_count(name, 0, strobes);
  endtask

  // Each result goes straight to the display, so every store waits on its producer
  task automatic exercise_alu(string name, bit same_ops);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    a = rand_bits(32);
    b = same_ops ? a : rand_bits(32);
    start_program();
    prog.push_back(encode_imm(OP1_ADDI, 4'd15, 4'd0, 16'd16));
    load_word(4'd1, a);
    load_word(4'd2, b);
    foreach (alu_ops[k]) begin
      prog.push_back(encode_reg(alu_ops[k], 4'd3, 4'd1, 4'd2));
      prog.push_back(display_store(4'd3));
      expect_hex(alu_expect(alu_ops[k], a, b));
    end
    foreach (imm_ops[k]) begin
      imm = rand_bits(16);
      prog.push_back(encode_imm(imm_ops[k], 4'd4, 4'd1, imm[15:0]));
      prog.push_back(display_store(4'd4));
      expect_hex(imm_expect(imm_ops[k], a, imm[15:0]));
    end
    prog.push_back(halt_word());
    run_program(name);
  endtask

  task automatic roundtrip_memory(string name);
    logic [31:0] w [4];
    logic [31:0] sh;
    logic [7:0]  base;
    logic [15:0] off;
    base = 8'(rand_bits(8));
    start_program();
    prog.push_back(encode_imm(OP1_ADDI, 4'd15, 4'd0, 16'd16));
    prog.push_back(encode_imm(OP1_ADDI, 4'd14, 4'd0, 16'd8));
    for (int k = 0; k < 4; k++) begin
      w[k] = rand_bits(32);
      off  = 16'((base + k) * 4);
      load_word(4'd1, w[k]);
      prog.push_back(encode_imm(OP1_SW, 4'd1, 4'd0, off));
    end
    for (int k = 3; k >= 0; k--) begin
      off = 16'((base + k) * 4);
      prog.push_back(encode_imm(OP1_LW, 4'd6, 4'd0, off));
      prog.push_back(display_store(4'd6));  // Uses the load right away
      expect_hex(w[k]);
      prog.push_back(encode_reg(OP2_RSHF, 4'd7, 4'd6, 4'd14));  // Upper bits into view
      prog.push_back(display_store(4'd7));
      sh = $signed(w[k]) >>> 8;
      expect_hex(sh);
    end
    prog.push_back(halt_word());
    run_program(name);
  endtask

  // Taken branch skips the first of two display stores
  task automatic branch_case(op1_e op, logic [3:0] rs, logic [3:0] rt,
                             logic [31:0] a, logic [31:0] b, int tag);
    prog.push_back(encode_imm(OP1_ADDI, 4'd12, 4'd0, 16'(16'h100 + tag)));
    prog.push_back(encode_imm(OP1_ADDI, 4'd13, 4'd0, 16'(16'h200 + tag)));
    prog.push_back(branch_word(op, rs, rt, 16'd1));
    prog.push_back(display_store(4'd12));
    prog.push_back(display_store(4'd13));
    if (!branch_expect(op, a, b)) expect_hex(32'h100 + tag);
    expect_hex(32'h200 + tag);
  endtask

  task automatic walk_branches(string name);
    logic [31:0] neg3;
    logic [31:0] pos7;
    neg3 = 32'hFFFF_FFFD;
    pos7 = 32'd7;
    start_program();
    prog.push_back(encode_imm(OP1_ADDI, 4'd1, 4'd0, neg3[15:0]));
    prog.push_back(encode_imm(OP1_ADDI, 4'd2, 4'd0, pos7[15:0]));
    prog.push_back(encode_imm(OP1_ADDI, 4'd3, 4'd0, neg3[15:0]));
    branch_case(OP1_BEQ, 4'd1, 4'd3, neg3, neg3, 0);
    branch_case(OP1_BEQ, 4'd1, 4'd2, neg3, pos7, 1);
    branch_case(OP1_BLT, 4'd1, 4'd2, neg3, pos7, 2);  // Signed compare
    branch_case(OP1_BLT, 4'd2, 4'd1, pos7, neg3, 3);
    branch_case(OP1_BLE, 4'd1, 4'd3, neg3, neg3, 4);
    branch_case(OP1_BLE, 4'd2, 4'd1, pos7, neg3, 5);
    branch_case(OP1_BNE, 4'd1, 4'd2, neg3, pos7, 6);
    branch_case(OP1_BNE, 4'd1, 4'd3, neg3, neg3, 7);
    prog.push_back(halt_word());
    run_program(name);
  endtask

  task automatic follow_jal(string name);
    logic [31:0] tgt;
    tgt = pc_of(4) / `CPU_INST_SIZE;
    start_program();
    prog.push_back(encode_imm(OP1_ADDI, 4'd1, 4'd0, 16'h0011));
    prog.push_back(encode_imm(OP1_JAL, 4'd5, 4'd0, tgt[15:0]));  // Absolute via r0
    prog.push_back(display_store(4'd1));
    prog.push_back(halt_word());
    prog.push_back(display_store(4'd5));
    expect_hex(pc_of(2));
    prog.push_back(encode_imm(OP1_ADDI, 4'd6, 4'd0, 16'(pc_of(0))));
    prog.push_back(encode_imm(OP1_JAL, 4'd7, 4'd6, 16'd9));  // Base plus nine words
    prog.push_back(display_store(4'd1));
    prog.push_back(halt_word());
    prog.push_back(display_store(4'd7));
    expect_hex(pc_of(7));
    prog.push_back(display_store(4'd1));
    expect_hex(32'h11);
    prog.push_back(halt_word());
    run_program(name);
  endtask

  initial begin
    reset     = 1'b1;
    run       = 1'b0;
    imem_wr   = 1'b0;
    imem_addr = '0;
    imem_data = '0;
    apply_reset();
    idle_after_reset("reset_idle");
    exercise_alu("alu_random", 1'b0);
    exercise_alu("alu_equal", 1'b1);
    roundtrip_memory("mem_roundtrip");
    walk_branches("branches");
    follow_jal("jal");
    $display("sim passed");
    $finish;
  end

endmodule
